// ==== u2_ctrl.f ====
source/u2_ctrl_pkg.sv
source/misc_settings.sv
source/vita_time.sv
source/status_readback.sv
source/u2_ctrl_top.sv
dv/u2_ctrl_checker.sv
dv/u2_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module u2_ctrl_tb -f u2_ctrl.f -o u2_ctrl_sim \
   && ./obj_dir/u2_ctrl_sim > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
echo "Simulation passed"
exit 0

// ==== dv/u2_ctrl_tb.sv ====
// Testbench top with clock, reset, LFSR stimulus, DUT, checker and timeout
`default_nettype none

module u2_ctrl_tb;
   timeunit 1ns;
   timeprecision 1ps;

   import u2_ctrl_pkg::*;

   localparam logic [31:0] TICKS = 32'd1000;
   // Test phases take about 3000 cycles
   localparam int MAX_CYCLES = 4000;

   logic        dsp_clk, rst_i, pps_i, rb_stb_i, sim_mode_i, pps_int_o, rb_ack_o;
   set_bus_t    set_i;
   hw_status_t  hw_i;
   misc_ctrl_t  ctrl_o;
   logic [3:0]  rb_addr_i, clock_divider_i;
   logic [7:0]  leds_o;
   logic [31:0] status_i, rb_data_o, rnd;
   logic [15:0] lfsr = 16'd64;
   int          cycles = 0;
   int          check_count, error_count;

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // One LFSR step per bit taken
   task automatic draw(input int n);
      int k;
      rnd = '0;
      for (k = 0; k < n; k++) begin
         lfsr = lfsr_step(lfsr);
         rnd  = {rnd[30:0], lfsr[0]};
      end
   endtask

   // Misc offsets 0..7 plus a seconds stage and a few foreign addresses
   function automatic logic [7:0] settings_addr(input logic [3:0] sel);
      case (sel)
         4'd12:   return SR_TIME64;
         4'd13:   return 8'd12;
         4'd14:   return 8'h80;
         4'd15:   return 8'hFF;
         default: return {5'd0, sel[2:0]};
      endcase
   endfunction

   task automatic settings_write(input logic [7:0] addr, input logic [31:0] data);
      @(negedge dsp_clk);
      set_i = {1'b1, addr, data};
      @(negedge dsp_clk);
      set_i.stb = 1'b0;
   endtask

   task automatic read_strobe(input logic [3:0] idx);
      @(negedge dsp_clk);
      rb_stb_i  = 1'b1;
      rb_addr_i = idx;
   endtask

   initial begin
      dsp_clk = 1'b0;
      forever #10 dsp_clk = ~dsp_clk;
   end

   //////////////////////////////////////////////////
   // Test sequence

   initial begin
      int i, j;
      rst_i           = 1'b1;
      set_i           = '0;
      // Every hardware LED source high while in reset
      hw_i            = '1;
      pps_i           = 1'b0;
      rb_stb_i        = 1'b0;
      rb_addr_i       = '0;
      status_i        = '0;
      sim_mode_i      = 1'b0;
      clock_divider_i = '0;
      repeat (4) @(posedge dsp_clk);
      @(negedge dsp_clk);
      rst_i = 1'b0;
      draw(4);
      hw_i = rnd[3:0];
      repeat (4) @(negedge dsp_clk);

      // Random settings writes, LED mux and readback traffic
      for (i = 0; i < 1200; i++) begin
         @(negedge dsp_clk);
         draw(14);
         set_i.stb  = rnd[13];
         set_i.addr = settings_addr(rnd[12:9]);
         hw_i       = rnd[8:5];
         rb_stb_i   = rnd[4];
         rb_addr_i  = rnd[3:0];
         draw(32);
         set_i.data = rnd;
         draw(32);
         status_i = rnd;
      end

      // Time loads a few ticks short of rollover and time reads across it
      for (i = 0; i < 12; i++) begin
         draw(32);
         settings_write(SR_TIME64, rnd);
         draw(3);
         settings_write(SR_TIME64 + 8'd1, TICKS - 32'd4 - {29'd0, rnd[2:0]});
         for (j = 0; j < 16; j++) begin
            read_strobe(j[0] ? RB_TIME_LO : RB_TIME_HI);
         end
         @(negedge dsp_clk);
         rb_stb_i = 1'b0;
      end

      // PPS pulses of random width and spacing
      for (i = 0; i < 30; i++) begin
         draw(7);
         @(negedge dsp_clk);
         pps_i = 1'b1;
         repeat (2 + rnd[6:4]) @(negedge dsp_clk);
         pps_i = 1'b0;
         repeat (8 + rnd[3:0]) @(negedge dsp_clk);
         read_strobe(RB_PPS_HI);
         read_strobe(RB_PPS_LO);
         @(negedge dsp_clk);
         rb_stb_i = 1'b0;
      end

      // Back-to-back reads over all 16 indices
      for (i = 0; i < 20; i++) begin
         draw(5);
         sim_mode_i      = rnd[4];
         clock_divider_i = rnd[3:0];
         for (j = 0; j < 16; j++) begin
            read_strobe(j[3:0]);
            draw(32);
            status_i = rnd;
         end
      end
      @(negedge dsp_clk);
      rb_stb_i = 1'b0;
      repeat (3) @(negedge dsp_clk);

      $display("Checks run: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0 && check_count > 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

   always @(posedge dsp_clk) begin
      cycles <= cycles + 1;
      if (cycles == MAX_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   //////////////////////////////////////////////////
   // DUT and checker

   u2_ctrl_top #(
      .TICKS_PER_SEC (TICKS)
   ) dut (
      .dsp_clk, .rst_i, .set_i, .hw_i, .pps_i,
      .rb_stb_i, .rb_addr_i, .status_i, .sim_mode_i, .clock_divider_i,
      .ctrl_o, .leds_o, .pps_int_o, .rb_data_o, .rb_ack_o
   );

   u2_ctrl_checker #(
      .TICKS_PER_SEC (TICKS)
   ) ctrl_checker (
      .dsp_clk, .rst_i, .set_i, .hw_i, .pps_i,
      .rb_stb_i, .rb_addr_i, .status_i, .sim_mode_i, .clock_divider_i,
      .ctrl_i        (ctrl_o),
      .leds_i        (leds_o),
      .pps_int_i     (pps_int_o),
      .rb_data_i     (rb_data_o),
      .rb_ack_i      (rb_ack_o),
      .check_count_o (check_count),
      .error_count_o (error_count)
   );

endmodule

`default_nettype wire

// ==== dv/u2_ctrl_checker.sv ====
// Reference model of control registers, time counter and readback, with output checks
`default_nettype none

module u2_ctrl_checker #(
   parameter logic [31:0] TICKS_PER_SEC = 32'd1000
) (
   input  wire                          dsp_clk,
   input  wire                          rst_i,
   // DUT inputs
   input  wire u2_ctrl_pkg::set_bus_t   set_i,
   input  wire u2_ctrl_pkg::hw_status_t hw_i,
   input  wire                          pps_i,
   input  wire                          rb_stb_i,
   input  wire [3:0]                    rb_addr_i,
   input  wire [31:0]                   status_i,
   input  wire                          sim_mode_i,
   input  wire [3:0]                    clock_divider_i,
   // DUT outputs
   input  wire u2_ctrl_pkg::misc_ctrl_t ctrl_i,
   input  wire [7:0]                    leds_i,
   input  wire                          pps_int_i,
   input  wire [31:0]                   rb_data_i,
   input  wire                          rb_ack_i,
   output int                           check_count_o,
   output int                           error_count_o
);
   timeunit 1ns;
   timeprecision 1ps;

   import u2_ctrl_pkg::*;

   // Model state, always the value from before the current edge
   logic [4:0]  m_clk;
   logic [3:0]  m_ser, m_adc;
   logic [7:0]  m_led_sw, m_led_src, hw_vec, exp_leds;
   logic        m_phy, m_ack, m_pps_int;
   logic        model_live = 1'b0;
   logic [31:0] m_secs, m_ticks, m_stage, m_rb_word;
   logic [63:0] m_pps_time;
   logic [4:0]  pps_hist;
   int          i;

   initial begin
      check_count_o = 0;
      error_count_o = 0;
   end

   task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
      check_count_o++;
      if (got !== exp) begin
         error_count_o++;
         $display("** Error at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   function automatic logic [31:0] expect_word(input logic [3:0] idx);
      case (idx)
         RB_STATUS:  return status_i;
         RB_MODE:    return {sim_mode_i, 27'd0, clock_divider_i};
         RB_TIME_HI: return m_secs;
         RB_TIME_LO: return m_ticks;
         RB_COMPAT:  return 32'h0007_0001;
         RB_PPS_HI:  return m_pps_time[63:32];
         RB_PPS_LO:  return m_pps_time[31:0];
         default:    return 32'd0;
      endcase
   endfunction

   //////////////////////////////////////////////////
   // Compare outputs, then advance the model

   always @(posedge dsp_clk) begin
      if (model_live) begin
         compare("ctrl_o", 64'(ctrl_i), 64'({m_clk, m_ser, m_adc, ~m_phy}));
         hw_vec = {3'b000, hw_i.run_tx, hw_i.run_rx, hw_i.clk_status, hw_i.link_good, 1'b0};
         for (i = 0; i < 8; i++) begin
            exp_leds[i] = m_led_src[i] ? hw_vec[i] : m_led_sw[i];
         end
         compare("leds_o", 64'(leds_i), 64'(exp_leds));
         compare("pps_int_o", 64'(pps_int_i), 64'(m_pps_int));
         compare("rb_ack_o", 64'(rb_ack_i), 64'(m_ack));
         if (m_ack) begin
            compare("rb_data_o", 64'(rb_data_i), 64'(m_rb_word));
         end
      end
      if (rst_i) begin
         {m_clk, m_ser, m_adc, m_led_sw, m_phy} = '0;
         m_led_src  = 8'h1E;
         {m_secs, m_ticks, m_stage} = '0;
         m_pps_time = '0;
         pps_hist   = '0;
         m_pps_int  = 1'b0;
         m_ack      = 1'b0;
         model_live = 1'b1;
      end else begin
         // Readback and PPS capture see the time from before this edge
         if (rb_stb_i) begin
            m_rb_word = expect_word(rb_addr_i);
         end
         m_ack    = rb_stb_i;
         pps_hist = {pps_hist[3:0], pps_i};
         // Pulse on the third edge after pps_i is first seen high
         m_pps_int = pps_hist[3] & ~pps_hist[4];
         if (m_pps_int) begin
            m_pps_time = {m_secs, m_ticks};
         end
         if (set_i.stb && set_i.addr == 8'd11) begin
            m_secs  = m_stage;
            m_ticks = set_i.data;
         end else if (m_ticks == TICKS_PER_SEC - 32'd1) begin
            m_ticks = '0;
            m_secs  = m_secs + 32'd1;
         end else begin
            m_ticks = m_ticks + 32'd1;
         end
         if (set_i.stb) begin
            case (set_i.addr)
               8'd0:    m_clk     = set_i.data[4:0];
               8'd1:    m_ser     = set_i.data[3:0];
               8'd2:    m_adc     = set_i.data[3:0];
               8'd3:    m_led_sw  = set_i.data[7:0];
               8'd4:    m_phy     = set_i.data[0];
               8'd6:    m_led_src = set_i.data[7:0];
               8'd10:   m_stage   = set_i.data;
               default: ;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// ==== source/u2_ctrl_top.sv ====
// Top level joining the settings registers, time counter and readback mux
`default_nettype none

module u2_ctrl_top #(
   parameter logic [31:0] TICKS_PER_SEC = 32'd100000000
) (
   input  wire                     dsp_clk,
   input  wire                     rst_i,
   // Settings bus and hardware status
   input  u2_ctrl_pkg::set_bus_t   set_i,
   input  u2_ctrl_pkg::hw_status_t hw_i,
   input  wire                     pps_i,
   // Readback port
   input  wire                     rb_stb_i,
   input  wire  [3:0]              rb_addr_i,
   input  wire  [31:0]             status_i,
   input  wire                     sim_mode_i,
   input  wire  [3:0]              clock_divider_i,
   // Control lines out
   output u2_ctrl_pkg::misc_ctrl_t ctrl_o,
   output logic [7:0]              leds_o,
   output logic                    pps_int_o,
   output logic [31:0]             rb_data_o,
   output logic                    rb_ack_o
);

   import u2_ctrl_pkg::*;

   vita_time_t time_now;
   vita_time_t time_pps;

   //////////////////////////////////////////////////
   // Misc control registers

   misc_settings misc_settings_i (
      .dsp_clk (dsp_clk),
      .rst_i   (rst_i),
      .set_i   (set_i),
      .hw_i    (hw_i),
      .ctrl_o  (ctrl_o),
      .leds_o  (leds_o)
   );

   //////////////////////////////////////////////////
   // Timekeeping

   vita_time #(
      .TICKS_PER_SEC (TICKS_PER_SEC)
   ) vita_time_i (
      .dsp_clk    (dsp_clk),
      .rst_i      (rst_i),
      .set_i      (set_i),
      .pps_i      (pps_i),
      .time_o     (time_now),
      .time_pps_o (time_pps),
      .pps_int_o  (pps_int_o)
   );

   //////////////////////////////////////////////////
   // Readback

   status_readback status_readback_i (
      .dsp_clk         (dsp_clk),
      .rst_i           (rst_i),
      .rb_stb_i        (rb_stb_i),
      .rb_addr_i       (rb_addr_i),
      .status_i        (status_i),
      .sim_mode_i      (sim_mode_i),
      .clock_divider_i (clock_divider_i),
      .time_i          (time_now),
      .time_pps_i      (time_pps),
      .rb_data_o       (rb_data_o),
      .rb_ack_o        (rb_ack_o)
   );

endmodule

`default_nettype wire

// ==== source/status_readback.sv ====
// Registered 16-word readback mux with one-cycle acknowledge
`default_nettype none

module status_readback (
   input  wire                     dsp_clk,
   input  wire                     rst_i,
   input  wire                     rb_stb_i,
   input  wire  [3:0]              rb_addr_i,
   input  wire  [31:0]             status_i,
   input  wire                     sim_mode_i,
   input  wire  [3:0]              clock_divider_i,
   input  u2_ctrl_pkg::vita_time_t time_i,
   input  u2_ctrl_pkg::vita_time_t time_pps_i,
   output logic [31:0]             rb_data_o,
   output logic                    rb_ack_o
);

   import u2_ctrl_pkg::*;

   logic [31:0] rb_word;

   // Word select, unlisted slots read zero
   always_comb begin
      case (rb_addr_i)
         RB_STATUS:  rb_word = status_i;
         RB_MODE:    rb_word = {sim_mode_i, 27'd0, clock_divider_i};
         RB_TIME_HI: rb_word = time_i.secs;
         RB_TIME_LO: rb_word = time_i.ticks;
         RB_COMPAT:  rb_word = COMPAT_NUM;
         RB_PPS_HI:  rb_word = time_pps_i.secs;
         RB_PPS_LO:  rb_word = time_pps_i.ticks;
         default:    rb_word = '0;
      endcase
   end

   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         rb_ack_o <= 1'b0;
      end else begin
         rb_ack_o <= rb_stb_i;
      end
   end

   // Data only moves on a strobe
   always_ff @(posedge dsp_clk) begin
      if (rb_stb_i) begin
         rb_data_o <= rb_word;
      end
   end

   a_ack_follows_stb: assert property (@(posedge dsp_clk) disable iff (rst_i)
      rb_ack_o |-> $past(rb_stb_i)) else $error("rb_ack_o without a strobe");

endmodule

`default_nettype wire

// ==== source/vita_time.sv ====
// Seconds/ticks time counter with settings-bus load and PPS capture
`default_nettype none

module vita_time #(
   parameter logic [31:0] TICKS_PER_SEC = 32'd100000000
) (
   input  wire                     dsp_clk,
   input  wire                     rst_i,
   input  u2_ctrl_pkg::set_bus_t   set_i,
   input  wire                     pps_i,
   output u2_ctrl_pkg::vita_time_t time_o,
   output u2_ctrl_pkg::vita_time_t time_pps_o,
   output logic                    pps_int_o
);

   import u2_ctrl_pkg::*;

   logic [31:0] secs_stage;
   vita_time_t  time_q;
   vita_time_t  time_pps_q;
   logic        load_secs;
   logic        load_time;
   logic        pps_s1, pps_s2;
   logic        pps_d1, pps_d2;
   logic        pps_edge;
   logic        pps_int_q;

   assign load_secs = set_i.stb && (set_i.addr == SR_TIME64);
   assign load_time = set_i.stb && (set_i.addr == SR_TIME64 + 8'd1);

   //////////////////////////////////////////////////
   // Counter and settings load

   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         secs_stage <= '0;
      end else if (load_secs) begin
         secs_stage <= set_i.data;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         time_q <= '0;
      end else if (load_time) begin
         // Ticks write commits the staged seconds too
         time_q <= {secs_stage, set_i.data};
      end else if (time_q.ticks == TICKS_PER_SEC - 32'd1) begin
         time_q.ticks <= '0;
         time_q.secs  <= time_q.secs + 32'd1;
      end else begin
         time_q.ticks <= time_q.ticks + 32'd1;
      end
   end

   //////////////////////////////////////////////////
   // PPS sync, edge detect and capture

   assign pps_edge = pps_d1 & ~pps_d2;

   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         {pps_s1, pps_s2, pps_d1, pps_d2} <= '0;
         pps_int_q  <= 1'b0;
         time_pps_q <= '0;
      end else begin
         pps_s1    <= pps_i;
         pps_s2    <= pps_s1;
         pps_d1    <= pps_s2;
         pps_d2    <= pps_d1;
         pps_int_q <= pps_edge;
         // Latch time as it stood just before the pulse
         if (pps_edge) begin
            time_pps_q <= time_q;
         end
      end
   end

   assign time_o     = time_q;
   assign time_pps_o = time_pps_q;
   assign pps_int_o  = pps_int_q;

   a_ticks_range: assert property (@(posedge dsp_clk) disable iff (rst_i)
      time_q.ticks < TICKS_PER_SEC) else $error("ticks beyond TICKS_PER_SEC");

   a_pps_single: assert property (@(posedge dsp_clk) disable iff (rst_i)
      pps_int_o |=> !pps_int_o) else $error("pps_int_o held two cycles");

endmodule

`default_nettype wire

// ==== source/misc_settings.sv ====
// Settings-bus register bank for misc control lines and the LED source mux
`default_nettype none

module misc_settings (
   input  wire                     dsp_clk,
   input  wire                     rst_i,
   input  u2_ctrl_pkg::set_bus_t   set_i,
   input  u2_ctrl_pkg::hw_status_t hw_i,
   output u2_ctrl_pkg::misc_ctrl_t ctrl_o,
   output logic [7:0]              leds_o
);

   import u2_ctrl_pkg::*;

   // Only the bits that reach an output are kept
   logic [4:0] clk_reg;
   logic [3:0] ser_reg;
   logic [3:0] adc_reg;
   logic [7:0] led_sw;
   logic       phy_reg;
   logic [7:0] led_src;
   logic [7:0] led_hw;

   //////////////////////////////////////////////////
   // Register writes

   always_ff @(posedge dsp_clk) begin
      if (rst_i) begin
         clk_reg <= '0;
         ser_reg <= '0;
         adc_reg <= '0;
         led_sw  <= '0;
         phy_reg <= 1'b0;
         led_src <= LED_SRC_RESET;
      end else if (set_i.stb) begin
         case (set_i.addr)
            SR_MISC + 8'd0: clk_reg <= set_i.data[4:0];
            SR_MISC + 8'd1: ser_reg <= set_i.data[3:0];
            SR_MISC + 8'd2: adc_reg <= set_i.data[3:0];
            SR_MISC + 8'd3: led_sw  <= set_i.data[7:0];
            SR_MISC + 8'd4: phy_reg <= set_i.data[0];
            SR_MISC + 8'd6: led_src <= set_i.data[7:0];
            // Offset 5 and foreign addresses fall through
            default: ;
         endcase
      end
   end

   //////////////////////////////////////////////////
   // Control line mapping

   always_comb begin
      ctrl_o.clock_ready = clk_reg[4];
      ctrl_o.clk_en      = clk_reg[3:2];
      ctrl_o.clk_sel     = clk_reg[1:0];
      ctrl_o.ser_enable  = ser_reg[3];
      ctrl_o.ser_prbsen  = ser_reg[2];
      ctrl_o.ser_loopen  = ser_reg[1];
      ctrl_o.ser_rx_en   = ser_reg[0];
      ctrl_o.adc_oe_a    = adc_reg[3];
      ctrl_o.adc_on_a    = adc_reg[2];
      ctrl_o.adc_oe_b    = adc_reg[1];
      ctrl_o.adc_on_b    = adc_reg[0];
      // Register holds the reset request, the pin is active low
      ctrl_o.phy_reset_n = ~phy_reg;
   end

   //////////////////////////////////////////////////
   // LEDs

   // Bit 0 and bits 7..5 have no hardware source
   assign led_hw = {3'b000, hw_i.run_tx, hw_i.run_rx, hw_i.clk_status,
                    hw_i.link_good, 1'b0};

   // Source bit 1 picks hardware, 0 picks software
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

   // PHY comes out of reset released
   a_phy_released: assert property (@(posedge dsp_clk) rst_i |=> ctrl_o.phy_reset_n)
      else $error("phy_reset_n low in the cycle after reset");

endmodule

`default_nettype wire

// ==== source/u2_ctrl_pkg.sv ====
// Settings addresses, readback indices, compatibility number and shared structs
`default_nettype none

package u2_ctrl_pkg;

   //////////////////////////////////////////////////
   // Settings bus address bases

   // Misc control block, offsets 0..6
   localparam logic [7:0] SR_MISC   = 8'd0;
   // Time counter, offset 0 stages seconds, offset 1 loads ticks
   localparam logic [7:0] SR_TIME64 = 8'd10;

   //////////////////////////////////////////////////
   // Constants

   // LEDs 1..4 follow hardware status out of reset
   localparam logic [7:0]  LED_SRC_RESET = 8'h1E;

   // Bump when the control map changes, major in upper half
   localparam logic [31:0] COMPAT_NUM = {16'd7, 16'd1};

   //////////////////////////////////////////////////
   // Readback word indices

   localparam logic [3:0] RB_STATUS  = 4'd8;
   localparam logic [3:0] RB_MODE    = 4'd9;
   localparam logic [3:0] RB_TIME_HI = 4'd10;
   localparam logic [3:0] RB_TIME_LO = 4'd11;
   localparam logic [3:0] RB_COMPAT  = 4'd12;
   localparam logic [3:0] RB_PPS_HI  = 4'd14;
   localparam logic [3:0] RB_PPS_LO  = 4'd15;

   //////////////////////////////////////////////////
   // Shared structs

   // One settings write, valid in any cycle with stb high
   typedef struct packed {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

   typedef struct packed {
      logic [31:0] secs;
      logic [31:0] ticks;
   } vita_time_t;

   // Clock, serdes, ADC and PHY lines, in register bit order
   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
      logic       ser_enable;
      logic       ser_prbsen;
      logic       ser_loopen;
      logic       ser_rx_en;
      logic       adc_oe_a;
      logic       adc_on_a;
      logic       adc_oe_b;
      logic       adc_on_b;
      logic       phy_reset_n;
   } misc_ctrl_t;

   // Hardware LED sources
   typedef struct packed {
      logic run_tx;
      logic run_rx;
      logic clk_status;
      logic link_good;
   } hw_status_t;

endpackage

`default_nettype wire
